// File: Bender.yml
package:
  name: cart_loader

sources:
  - cart_pkg.sv
  - load_bus_if.sv
  - region_scanner.sv
  - cart_id_matcher.sv
  - cart_profile_builder.sv
  - cart_loader.sv
  - target: simulation
    files:
      - tb_cart_loader.sv

// File: cart_id_matcher.sv
// Product ID quirk matcher
module cart_id_matcher (
	input  logic             clk_sys,
	input  logic             rst_n,
	load_bus_if.snoop        bus,
	output cart_pkg::quirk_t quirks
);
	import cart_pkg::*;

	logic                dl_prev;
	logic                id_wr;
	logic [id_len*8-1:0] cart_id;

	// Known titles, each needing exactly one quirk
	function automatic quirk_t lookup(input logic [id_len*8-1:0] id);
		quirk_t q;
		q = '0;
		case (id)
			"T-081276": q.sram   = 1'b1;
			"T-81406 ": q.sram   = 1'b1;
			"T-081586": q.sram   = 1'b1;
			"T-81576 ": q.sram   = 1'b1;
			"T-81476 ": q.sram   = 1'b1;
			"MK-1215 ": q.eeprom = 1'b1;
			"G-4060  ": q.eeprom = 1'b1;
			"00001211": q.eeprom = 1'b1;
			"MK-1228 ": q.eeprom = 1'b1;
			"G-5538  ": q.eeprom = 1'b1;
			"00004076": q.eeprom = 1'b1;
			"T-12046 ": q.eeprom = 1'b1;
			"T-12053 ": q.eeprom = 1'b1;
			"G-4524  ": q.eeprom = 1'b1;
			"T-113016": q.noram  = 1'b1;
			"T-89016 ": q.fifo   = 1'b1;
			"T-574023": q.pier   = 1'b1;
			"T-574013": q.pier   = 1'b1;
			"TITAN002": q.ttn2   = 1'b1;
			"MK-1229 ": q.svp    = 1'b1;
			"G-7001  ": q.svp    = 1'b1;
			"T-35036 ": q.fmbusy = 1'b1;
			"T-25073 ": q.fmbusy = 1'b1;
			"MK-1137-": q.fmbusy = 1'b1;
			default: ;
		endcase
		return q;
	endfunction

	assign id_wr = bus.wr & bus.download;

	//////////////////////////////////////////////////////////////////////
	// ID assembly
	//////////////////////////////////////////////////////////////////////

	// Words arrive byte swapped, ID starts on the odd byte at 0x183
	always_ff @(posedge clk_sys) begin
		if (id_wr) begin
			case (bus.addr)
				id_first_addr:         cart_id[63:56] <= bus.data[15:8];
				id_first_addr + 25'd2: cart_id[55:40] <= {bus.data[7:0], bus.data[15:8]};
				id_first_addr + 25'd4: cart_id[39:24] <= {bus.data[7:0], bus.data[15:8]};
				id_first_addr + 25'd6: cart_id[23:8]  <= {bus.data[7:0], bus.data[15:8]};
				id_last_addr:          cart_id[7:0]   <= bus.data[7:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dl_prev <= 1'b0;
			quirks  <= '0;
		end else begin
			dl_prev <= bus.download;
			if (bus.download & ~dl_prev) quirks <= '0;
			if (id_wr && bus.addr == id_check_addr) quirks <= quirks | lookup(cart_id);
		end
	end

	// Flags are cleared per image so a title never carries two quirks
	a_single_quirk: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		$onehot0(quirks)
	);

endmodule

// File: cart_loader.sv
// Cartridge header loader top
module cart_loader (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 download,
	input  logic                 wr,
	input  logic [24:0]          addr,
	input  logic [15:0]          data,
	input  logic [7:0]           file_index,
	input  cart_pkg::auto_mode_t auto_mode,
	input  cart_pkg::priority_t  prio,
	output cart_pkg::region_t    region,
	output logic                 region_set,
	output cart_pkg::quirk_t     quirks
);
	import cart_pkg::*;

	logic   hdr_j;
	logic   hdr_u;
	logic   hdr_e;
	logic   hdr_ready;
	logic   dl_start;
	quirk_t id_quirks;

	// Host stream into the shared bus
	load_bus_if bus ();

	assign bus.download = download;
	assign bus.wr       = wr;
	assign bus.addr     = addr;
	assign bus.data     = data;

	region_scanner i_region_scanner (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.bus       (bus),
		.hdr_j     (hdr_j),
		.hdr_u     (hdr_u),
		.hdr_e     (hdr_e),
		.hdr_ready (hdr_ready),
		.dl_start  (dl_start)
	);

	cart_id_matcher i_cart_id_matcher (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.bus     (bus),
		.quirks  (id_quirks)
	);

	cart_profile_builder i_cart_profile_builder (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.hdr_j          (hdr_j),
		.hdr_u          (hdr_u),
		.hdr_e          (hdr_e),
		.hdr_ready      (hdr_ready),
		.dl_start       (dl_start),
		.quirks         (id_quirks),
		.file_index     (file_index),
		.auto_mode      (auto_mode),
		.prio           (prio),
		.region         (region),
		.region_set     (region_set),
		.profile_quirks (quirks)
	);

endmodule

// File: cart_pkg.sv
// Cartridge loader definitions
package cart_pkg;

	//////////////////////////////////////////////////////////////////////
	// Host bus widths
	//////////////////////////////////////////////////////////////////////

	// Byte address width of the host stream
	localparam int addr_w = 25;
	// One bus word carries two ROM bytes
	localparam int data_w = 16;

	//////////////////////////////////////////////////////////////////////
	// Cartridge header layout, byte addresses
	//////////////////////////////////////////////////////////////////////

	// Region letters, two per word at the low address
	localparam logic [addr_w-1:0] hdr_region_lo_addr = 25'h1F0;
	localparam logic [addr_w-1:0] hdr_region_hi_addr = 25'h1F2;

	// First word past the header
	localparam logic [addr_w-1:0] hdr_end_addr = 25'h200;

	// Product ID words, first and last
	localparam logic [addr_w-1:0] id_first_addr = 25'h182;
	localparam logic [addr_w-1:0] id_last_addr  = 25'h18A;

	// ID is complete once this word is written
	localparam logic [addr_w-1:0] id_check_addr = 25'h18C;

	// Product ID length in bytes
	localparam int id_len = 8;

	//////////////////////////////////////////////////////////////////////
	// Profile types
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		region_jp = 2'd0,
		region_us = 2'd1,
		region_eu = 2'd2
	} region_t;

	typedef enum logic [1:0] {
		auto_header,
		auto_file_ext,
		auto_off
	} auto_mode_t;

	// Region preference, highest first
	typedef enum logic [1:0] {
		prio_us_eu_jp,
		prio_eu_us_jp,
		prio_us_jp_eu,
		prio_jp_us_eu
	} priority_t;

	// Per-title system quirks
	typedef struct packed {
		logic sram;
		logic eeprom;
		logic fifo;
		logic noram;
		logic pier;
		logic ttn2;
		logic svp;
		logic fmbusy;
	} quirk_t;

endpackage

// File: cart_profile_builder.sv
// Region and quirk profile builder
module cart_profile_builder (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 hdr_j,
	input  logic                 hdr_u,
	input  logic                 hdr_e,
	input  logic                 hdr_ready,
	input  logic                 dl_start,
	input  cart_pkg::quirk_t     quirks,
	input  logic [7:0]           file_index,
	input  cart_pkg::auto_mode_t auto_mode,
	input  cart_pkg::priority_t  prio,
	output cart_pkg::region_t    region,
	output logic                 region_set,
	output cart_pkg::quirk_t     profile_quirks
);
	import cart_pkg::*;

	logic ready_prev;
	logic ready_rise;
	logic ready_fall;

	// First present region in preference order, else the order's head
	function automatic region_t pick(input logic [2:0] present, input priority_t p);
		region_t ord [3];
		region_t r;
		case (p)
			prio_us_eu_jp: ord = '{region_us, region_eu, region_jp};
			prio_eu_us_jp: ord = '{region_eu, region_us, region_jp};
			prio_us_jp_eu: ord = '{region_us, region_jp, region_eu};
			default:       ord = '{region_jp, region_us, region_eu};
		endcase
		r = ord[0];
		for (int i = 2; i >= 0; i--) begin
			if (present[ord[i]]) r = ord[i];
		end
		return r;
	endfunction

	assign ready_rise = hdr_ready & ~ready_prev;
	assign ready_fall = ready_prev & ~hdr_ready;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ready_prev     <= 1'b0;
			region         <= region_jp;
			region_set     <= 1'b0;
			profile_quirks <= '0;
		end else begin
			ready_prev <= hdr_ready;
			if (dl_start | ready_fall) region_set <= 1'b0;

			if (ready_rise) begin
				profile_quirks <= quirks;
				case (auto_mode)
					auto_header: begin
						// Present vector is indexed by region code
						region     <= pick({hdr_e, hdr_u, hdr_j}, prio);
						region_set <= 1'b1;
					end
					auto_file_ext: begin
						region     <= region_t'(file_index[7:6]);
						region_set <= |file_index;
					end
					default: ;
				endcase
			end
		end
	end

	a_region_legal: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		region_set |-> !(&region)
	);

endmodule

// File: flist.f
cart_pkg.sv
load_bus_if.sv
region_scanner.sv
cart_id_matcher.sv
cart_profile_builder.sv
cart_loader.sv
tb_cart_loader.sv

// File: load_bus_if.sv
// Host write stream bus
interface load_bus_if;
	import cart_pkg::*;

	// High for the whole image transfer
	logic              download;
	// One cycle per word
	logic              wr;
	logic [addr_w-1:0] addr;
	// Low byte sits at the even address
	logic [data_w-1:0] data;

	modport source (
		output download, wr, addr, data
	);

	// Passive observers of the stream
	modport snoop (
		input download, wr, addr, data
	);

endinterface

// File: region_scanner.sv
// Header region scanner
module region_scanner (
	input  logic      clk_sys,
	input  logic      rst_n,
	load_bus_if.snoop bus,
	output logic      hdr_j,
	output logic      hdr_u,
	output logic      hdr_e,
	output logic      hdr_ready,
	output logic      dl_start
);
	import cart_pkg::*;

	logic       dl_prev;
	logic       hdr_wr;
	// Flag order is j, u, e
	logic [2:0] flags;

	// One region letter to its flag, anything else printable counts as EU
	function automatic logic [2:0] classify(input logic [7:0] b);
		if (b == "J") return 3'b100;
		if (b == "U") return 3'b010;
		if (b >= "0" && b <= "Z") return 3'b001;
		return 3'b000;
	endfunction

	assign dl_start = bus.download & ~dl_prev;
	assign hdr_wr   = bus.wr & bus.download;

	assign {hdr_j, hdr_u, hdr_e} = flags;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dl_prev   <= 1'b0;
			flags     <= '0;
			hdr_ready <= 1'b0;
		end else begin
			dl_prev <= bus.download;

			// New image, forget the previous header
			if (dl_start) flags <= '0;
			if (dl_prev & ~bus.download) hdr_ready <= 1'b0;

			if (hdr_wr) begin
				case (bus.addr)
					hdr_region_lo_addr: begin
						flags <= flags | classify(bus.data[7:0]) | classify(bus.data[15:8]);
					end
					hdr_region_hi_addr: flags <= flags | classify(bus.data[7:0]);
					hdr_end_addr: hdr_ready <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	// A flag only rises from a header write during a download
	a_flags_need_download: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		!bus.download |=> ((flags & ~$past(flags)) == 3'b000)
	);

endmodule

// File: tb_cart_loader.sv
// Cartridge loader testbench
module tb_cart_loader;
	import cart_pkg::*;

	typedef struct packed {
		region_t region;
		logic    set;
		quirk_t  quirks;
	} profile_t;

	// Number of images in the run sets the watchdog limit
	localparam int     image_count = 67;
	localparam longint timeout = image_count * 'h204 * 2 * 100 + image_count * 2000 + 100000;

	logic        clk_sys;
	logic        rst_n;
	logic        download;
	logic        wr;
	logic [24:0] addr;
	logic [15:0] data;
	logic [7:0]  file_index;
	auto_mode_t  auto_mode;
	priority_t   prio;
	region_t     region;
	logic        region_set;
	quirk_t      quirks;

	integer      seed = 56517;
	int unsigned cycle = 0;
	logic [7:0]  image [0:'h203];
	region_t     last_region = region_jp;
	profile_t    exp_q [$];
	int unsigned due_q [$];
	string       name_q [$];

	// Known titles and their quirk bytes with sram in bit 7 down to fmbusy in bit 0
	logic [63:0] id_table [24] = '{
		"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ", "MK-1215 ",
		"G-4060  ", "00001211", "MK-1228 ", "G-5538  ", "00004076", "T-12046 ",
		"T-12053 ", "G-4524  ", "T-113016", "T-89016 ", "T-574023", "T-574013",
		"TITAN002", "MK-1229 ", "G-7001  ", "T-35036 ", "T-25073 ", "MK-1137-"
	};
	logic [7:0] id_quirk [24] = '{
		8'h80, 8'h80, 8'h80, 8'h80, 8'h80, 8'h40, 8'h40, 8'h40, 8'h40, 8'h40, 8'h40, 8'h40,
		8'h40, 8'h40, 8'h10, 8'h20, 8'h08, 8'h08, 8'h04, 8'h02, 8'h02, 8'h01, 8'h01, 8'h01
	};
	// Upper two bits stay below 3 so no illegal region is produced
	logic [7:0] fidx_list [6] = '{8'h00, 8'h01, 8'h45, 8'h80, 8'h3F, 8'hA7};

	cart_loader i_cart_loader (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.download   (download),
		.wr         (wr),
		.addr       (addr),
		.data       (data),
		.file_index (file_index),
		.auto_mode  (auto_mode),
		.prio       (prio),
		.region     (region),
		.region_set (region_set),
		.quirks     (quirks)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) cycle <= cycle + 1;

	//////////////////////////////////////////////////////////////////////
	// Expected profile and compare tasks
	//////////////////////////////////////////////////////////////////////

	function automatic profile_t expected_profile(input logic [23:0] rbytes,
			input logic [63:0] id, input auto_mode_t mode, input priority_t p,
			input logic [7:0] fidx, input region_t prev);
		profile_t   pr;
		logic [7:0] b;
		logic       jp;
		logic       us;
		logic       eu;
		pr = '{region: prev, set: 1'b0, quirks: '0};
		{jp, us, eu} = 3'b000;
		for (int k = 0; k < 24; k++) begin
			if (id == id_table[k]) pr.quirks = quirk_t'(id_quirk[k]);
		end
		for (int k = 0; k < 3; k++) begin
			b = rbytes[23 - 8*k -: 8];
			jp |= (b == "J");
			us |= (b == "U");
			eu |= (b != "J" && b != "U" && b >= "0" && b <= "Z");
		end
		if (mode == auto_header) begin
			pr.set = 1'b1;
			case (p)
				prio_us_eu_jp:
					pr.region = us ? region_us : eu ? region_eu : jp ? region_jp : region_us;
				prio_eu_us_jp:
					pr.region = eu ? region_eu : us ? region_us : jp ? region_jp : region_eu;
				prio_us_jp_eu:
					pr.region = us ? region_us : jp ? region_jp : eu ? region_eu : region_us;
				default:
					pr.region = jp ? region_jp : us ? region_us : eu ? region_eu : region_jp;
			endcase
		end else if (mode == auto_file_ext) begin
			pr.region = region_t'(fidx[7:6]);
			pr.set    = (fidx != 8'h00);
		end
		return pr;
	endfunction

	task automatic check_region(input string name, input region_t exp, input region_t act);
		if (exp !== act) begin
			$display("Fail %s region: expected %0d, actual %0d", name, exp, act);
			$display("Checks failed");
			$fatal(1, "Region mismatch");
		end
	endtask

	task automatic check_set(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Fail %s region_set: expected %b, actual %b", name, exp, act);
			$display("Checks failed");
			$fatal(1, "Region set mismatch");
		end
	endtask

	task automatic check_quirks(input string name, input quirk_t exp, input quirk_t act);
		if (exp !== act) begin
			$display("Fail %s quirks: expected %h, actual %h", name, exp, act);
			$display("Checks failed");
			$fatal(1, "Quirk mismatch");
		end
	endtask

	// region_set is low one cycle before its due slot and valid in it
	always @(negedge clk_sys) begin
		if (due_q.size() != 0) begin
			if (cycle == due_q[0] - 1) begin
				check_set({name_q[0], " early"}, 1'b0, region_set);
			end else if (cycle == due_q[0]) begin
				check_set(name_q[0], exp_q[0].set, region_set);
				check_region(name_q[0], exp_q[0].region, region);
				check_quirks(name_q[0], exp_q[0].quirks, quirks);
				void'(due_q.pop_front());
				void'(exp_q.pop_front());
				void'(name_q.pop_front());
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	// Mask bit 2 places J and bit 1 places U and bit 0 an EU letter
	// Slots rotate with rot
	function automatic logic [23:0] region_letters(input int m, input int rot);
		logic [7:0] slot [3];
		logic [7:0] ltr [3];
		slot = '{" ", " ", " "};
		ltr  = '{"J", "U", (rot[0] ? "7" : "E")};
		for (int k = 0; k < 3; k++) begin
			if (m[2-k]) slot[(k + rot) % 3] = ltr[k];
		end
		return {slot[0], slot[1], slot[2]};
	endfunction

	task automatic load_image(input string name, input logic [23:0] rbytes,
			input logic [63:0] id, input auto_mode_t mode, input priority_t p,
			input logic [7:0] fidx);
		profile_t    exp;
		logic [31:0] rnd;
		for (int a = 0; a < 'h204; a++) begin
			rnd = $random(seed);
			image[a] = rnd[7:0];
		end
		{image['h1F0], image['h1F1], image['h1F2]} = rbytes;
		// A letter in the upper byte of the second region word is ignored
		image['h1F3] = "J";
		for (int k = 0; k < id_len; k++) image['h183 + k] = id[63 - 8*k -: 8];
		exp = expected_profile(rbytes, id, mode, p, fidx, last_region);
		last_region = exp.region;
		@(negedge clk_sys);
		auto_mode  = mode;
		prio       = p;
		file_index = fidx;
		download   = 1'b1;
		for (int a = 0; a < 'h204; a += 2) begin
			@(negedge clk_sys);
			wr   = 1'b1;
			addr = 25'(a);
			data = {image[a+1], image[a]};
			if (addr == hdr_end_addr) begin
				exp_q.push_back(exp);
				due_q.push_back(cycle + 2);
				name_q.push_back(name);
			end
			rnd = $random(seed);
			if (rnd[0]) begin
				@(negedge clk_sys);
				wr = 1'b0;
			end
		end
		@(negedge clk_sys);
		wr = 1'b0;
		repeat (2) @(negedge clk_sys);
		download = 1'b0;
		repeat (3) @(negedge clk_sys);
		check_set({name, " after download"}, 1'b0, region_set);
		check_region({name, " after download"}, exp.region, region);
	endtask

	initial begin
		logic [63:0] rid;
		download   = 1'b0;
		wr         = 1'b0;
		addr       = '0;
		data       = '0;
		file_index = '0;
		auto_mode  = auto_header;
		prio       = prio_us_eu_jp;
		rst_n      = 1'b0;
		repeat (8) @(negedge clk_sys);
		rst_n = 1'b1;

		for (int p = 0; p < 4; p++) begin
			for (int m = 0; m < 8; m++) begin
				load_image("header_region", region_letters(m, p), id_table[m*3], auto_header,
					priority_t'(p), 8'h00);
			end
		end

		for (int k = 0; k < 24; k++) begin
			load_image("quirk_title", {"U", " ", " "}, id_table[k], auto_header,
				prio_us_eu_jp, 8'h00);
		end
		rid = {$random(seed), $random(seed)};
		load_image("random_id", {"J", "E", " "}, rid, auto_header, prio_jp_us_eu, 8'h00);

		foreach (fidx_list[k]) begin
			load_image("file_ext", {"U", "U", " "}, id_table[5], auto_file_ext,
				prio_us_eu_jp, fidx_list[k]);
		end

		// Region must hold the last file extension result
		load_image("auto_off", {"J", " ", " "}, id_table[16], auto_off, prio_jp_us_eu, 8'h00);
		load_image("auto_off", {"U", "E", "J"}, rid, auto_off, prio_us_eu_jp, 8'h40);

		load_image("back_to_back_first", {"J", "J", "J"}, id_table[19], auto_header,
			prio_us_eu_jp, 8'h00);
		load_image("back_to_back_second", {" ", " ", " "}, rid, auto_header,
			prio_eu_us_jp, 8'h00);

		if (due_q.size() == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Checks failed");
			$fatal(1, "Profiles were left unchecked at the end of the run");
		end
	end

	initial begin
		#(timeout);
		$display("Checks failed");
		$fatal(1, "Run timed out before all images were checked");
	end

endmodule
